// File: rtl/ring_pkg.sv
// ring network package
// port count, message field widths and field positions

package ring_pkg;

  // ------------------------------
  // network size
  // ------------------------------

  // terminals, one router per terminal
  localparam int NUM_PORTS = 8;

  // ------------------------------
  // message fields
  // ------------------------------

  // width of src or dest index
  localparam int PORT_W = 3;

  // payload and opaque tag widths
  localparam int PAYLOAD_W = 8;
  localparam int OPAQUE_W  = 8;

  // field order, low to high
  //   payload | opaque | src | dest
  localparam int PAYLOAD_LSB = 0;
  localparam int OPAQUE_LSB  = PAYLOAD_LSB + PAYLOAD_W;
  localparam int SRC_LSB     = OPAQUE_LSB + OPAQUE_W;
  localparam int DEST_LSB    = SRC_LSB + PORT_W;

  // full message, 22 bits
  localparam int MSG_W = DEST_LSB + PORT_W;

  // ------------------------------
  // buffering
  // ------------------------------

  // ring buffer per router
  // needs two free slots for an injection (bubble rule)
  localparam int RING_DEPTH = 4;

  // injection queue per terminal
  localparam int INJ_DEPTH = 2;

endpackage

// File: rtl/ring_fifo.sv
`timescale 1ns/1ps

// ring message queue
// val/rdy circular buffer with occupancy count and two-slot space flag

module ring_fifo #(
  parameter int DEPTH = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // write side
  input  logic                       enq_val,
  output logic                       enq_rdy,
  input  logic [ring_pkg::MSG_W-1:0] enq_msg,

  // read side
  output logic                       deq_val,
  input  logic                       deq_rdy,
  output logic [ring_pkg::MSG_W-1:0] deq_msg,

  // at least two entries free
  output logic                       space2
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // storage, no reset
  logic [ring_pkg::MSG_W-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic enq_fire;
  logic deq_fire;

  // wrap at DEPTH, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ------------------------------
  // handshake
  // ------------------------------

  // rdy from count only, never from enq_val
  assign enq_rdy  = (count != CNT_W'(DEPTH));
  assign deq_val  = (count != '0);
  assign space2   = (count <= CNT_W'(DEPTH - 2));

  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  // head straight from storage
  // no bypass, a write shows up one cycle later
  assign deq_msg  = mem[rd_ptr];

  // ------------------------------
  // pointers and count
  // ------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (enq_fire)
        wr_ptr <= ptr_inc(wr_ptr);
      if (deq_fire)
        rd_ptr <= ptr_inc(rd_ptr);
      // simultaneous enq and deq keeps the count
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // data write
  always_ff @(posedge clk)
  begin
    if (enq_fire)
      mem[wr_ptr] <= enq_msg;
  end

endmodule

// File: rtl/ring_route_ctrl.sv
`timescale 1ns/1ps

// ring router control
// per-cycle eject, forward and inject decisions, ring traffic first

module ring_route_ctrl #(
  parameter int unsigned ROUTER_ID = 0
) (
  // ring queue head
  input  logic                        ring_head_val,
  input  logic [ring_pkg::PORT_W-1:0] ring_head_dest,

  // injection queue head
  input  logic                        inj_head_val,
  input  logic [ring_pkg::PORT_W-1:0] inj_head_dest,

  // terminal output ready
  input  logic                        out_rdy,

  // downstream ring buffer state
  input  logic                        next_rdy,
  input  logic                        next_space2,

  // dequeue strobes
  output logic                        ring_deq,
  output logic                        inj_deq,

  // terminal output steering
  output logic                        out_sel_inj,
  output logic                        out_val,

  // ring link steering
  output logic                        fwd_val,
  output logic                        fwd_sel_inj
);

  // own index at dest width
  localparam logic [ring_pkg::PORT_W-1:0] MY_ID = ROUTER_ID[ring_pkg::PORT_W-1:0];

  // ring head claims
  logic ring_eject;
  logic ring_fwd;

  // injection head claims
  logic inj_local;
  logic inj_eject;
  logic inj_fwd;

  // ------------------------------
  // ring head
  // ------------------------------

  // arrived at its dest, wants the terminal
  assign ring_eject = ring_head_val && (ring_head_dest == MY_ID);

  // passing through, wants the link
  assign ring_fwd   = ring_head_val && (ring_head_dest != MY_ID);

  // ------------------------------
  // injection head
  // ------------------------------

  assign inj_local = (inj_head_dest == MY_ID);

  // send to self, only if ring head leaves the terminal free
  assign inj_eject = inj_head_val && inj_local && !ring_eject;

  // bubble rule
  // two free slots downstream keep one slot for ring traffic,
  // so a full ring can always drain
  assign inj_fwd   = inj_head_val && !inj_local && !ring_fwd && next_space2;

  // ------------------------------
  // grants
  // ------------------------------

  // terminal port
  assign out_val     = ring_eject || inj_eject;
  assign out_sel_inj = !ring_eject;

  // ring link
  assign fwd_val     = ring_fwd || inj_fwd;
  assign fwd_sel_inj = !ring_fwd;

  // pop a head once its chosen port takes it
  assign ring_deq = (ring_eject && out_rdy) || (ring_fwd && next_rdy);
  assign inj_deq  = (inj_eject && out_rdy) || (inj_fwd && next_rdy);

endmodule

// File: rtl/ring_router.sv
`timescale 1ns/1ps

// ring router
// one ring stop, ring buffer and injection queue with output steering

module ring_router #(
  parameter int unsigned ROUTER_ID = 0
) (
  input  logic                       clk,
  input  logic                       rst_n,

  // terminal in
  input  logic                       in_val,
  output logic                       in_rdy,
  input  logic [ring_pkg::MSG_W-1:0] in_msg,

  // terminal out
  output logic                       out_val,
  input  logic                       out_rdy,
  output logic [ring_pkg::MSG_W-1:0] out_msg,

  // link from upstream router
  input  logic                       prev_val,
  output logic                       prev_rdy,
  input  logic [ring_pkg::MSG_W-1:0] prev_msg,
  output logic                       prev_space2,

  // link to downstream router
  output logic                       next_val,
  input  logic                       next_rdy,
  output logic [ring_pkg::MSG_W-1:0] next_msg,
  input  logic                       next_space2
);

  // queue heads
  logic                       ring_val;
  logic                       ring_deq;
  logic [ring_pkg::MSG_W-1:0] ring_msg;
  logic                       inj_val;
  logic                       inj_deq;
  logic [ring_pkg::MSG_W-1:0] inj_msg;

  // head dest fields
  logic [ring_pkg::PORT_W-1:0] ring_dest;
  logic [ring_pkg::PORT_W-1:0] inj_dest;

  // steering
  logic out_sel_inj;
  logic fwd_sel_inj;

  // injected message stalled on the terminal port
  logic eject_lock;
  logic ring_val_ctrl;

  // ------------------------------
  // queues
  // ------------------------------

  ring_fifo #(.DEPTH(ring_pkg::RING_DEPTH)) ring_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_val (prev_val),
    .enq_rdy (prev_rdy),
    .enq_msg (prev_msg),
    .deq_val (ring_val),
    .deq_rdy (ring_deq),
    .deq_msg (ring_msg),
    .space2  (prev_space2)
  );

  ring_fifo #(.DEPTH(ring_pkg::INJ_DEPTH)) inj_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .enq_val (in_val),
    .enq_rdy (in_rdy),
    .enq_msg (in_msg),
    .deq_val (inj_val),
    .deq_rdy (inj_deq),
    .deq_msg (inj_msg),
    .space2  ()
  );

  assign ring_dest = ring_msg[ring_pkg::DEST_LSB +: ring_pkg::PORT_W];
  assign inj_dest  = inj_msg[ring_pkg::DEST_LSB +: ring_pkg::PORT_W];

  // ------------------------------
  // control
  // ------------------------------

  // out_val must hold once offered
  // a stalled injected message keeps the terminal,
  // an arriving ejecting ring head waits behind it
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      eject_lock <= 1'b0;
    else
      eject_lock <= out_val && out_sel_inj && !out_rdy;
  end

  // hide only an ejecting ring head, forwarding continues
  assign ring_val_ctrl = ring_val
                         && !(eject_lock && (ring_dest == ROUTER_ID[ring_pkg::PORT_W-1:0]));

  ring_route_ctrl #(.ROUTER_ID(ROUTER_ID)) ctrl (
    .ring_head_val  (ring_val_ctrl),
    .ring_head_dest (ring_dest),
    .inj_head_val   (inj_val),
    .inj_head_dest  (inj_dest),
    .out_rdy        (out_rdy),
    .next_rdy       (next_rdy),
    .next_space2    (next_space2),
    .ring_deq       (ring_deq),
    .inj_deq        (inj_deq),
    .out_sel_inj    (out_sel_inj),
    .out_val        (out_val),
    .fwd_val        (next_val),
    .fwd_sel_inj    (fwd_sel_inj)
  );

  // ------------------------------
  // output muxes
  // ------------------------------

  assign out_msg  = out_sel_inj ? inj_msg : ring_msg;
  assign next_msg = fwd_sel_inj ? inj_msg : ring_msg;

endmodule

// File: rtl/ring_net.sv
`timescale 1ns/1ps

// ring network top
// eight routers closed into a unidirectional ring, flattened terminal ports

module ring_net (
  input  logic                                           clk,
  input  logic                                           rst_n,

  // terminals into the network
  input  logic [ring_pkg::NUM_PORTS-1:0]                 in_val,
  output wire  [ring_pkg::NUM_PORTS-1:0]                 in_rdy,
  input  logic [ring_pkg::NUM_PORTS*ring_pkg::MSG_W-1:0] in_msg,

  // network out to the terminals
  output wire  [ring_pkg::NUM_PORTS-1:0]                 out_val,
  input  logic [ring_pkg::NUM_PORTS-1:0]                 out_rdy,
  output wire  [ring_pkg::NUM_PORTS*ring_pkg::MSG_W-1:0] out_msg
);

  // ring links, index k is the link from router k to router k+1
  wire [ring_pkg::NUM_PORTS-1:0] ring_val;
  wire [ring_pkg::NUM_PORTS-1:0] ring_rdy;
  wire [ring_pkg::NUM_PORTS-1:0] ring_space2;
  wire [ring_pkg::MSG_W-1:0]     ring_msg [ring_pkg::NUM_PORTS];

  // ------------------------------
  // router stops
  // ------------------------------

  for (genvar k = 0; k < ring_pkg::NUM_PORTS; k++)
  begin : g_stop
    // upstream link, router 0 closes on router 7
    localparam int PREV = (k + ring_pkg::NUM_PORTS - 1) % ring_pkg::NUM_PORTS;

    ring_router #(.ROUTER_ID(k)) router (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_val      (in_val[k]),
      .in_rdy      (in_rdy[k]),
      .in_msg      (in_msg[k*ring_pkg::MSG_W +: ring_pkg::MSG_W]),
      .out_val     (out_val[k]),
      .out_rdy     (out_rdy[k]),
      .out_msg     (out_msg[k*ring_pkg::MSG_W +: ring_pkg::MSG_W]),
      .prev_val    (ring_val[PREV]),
      .prev_rdy    (ring_rdy[PREV]),
      .prev_msg    (ring_msg[PREV]),
      .prev_space2 (ring_space2[PREV]),
      .next_val    (ring_val[k]),
      .next_rdy    (ring_rdy[k]),
      .next_msg    (ring_msg[k]),
      .next_space2 (ring_space2[k])
    );
  end

endmodule

// File: bench/ring_clk_gen.sv
`timescale 1ns/1ps

// testbench clock and reset
// free running clock, reset held low for the first cycles

module ring_clk_gen #(
  parameter int CLK_PERIOD = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: bench/ring_net_sva.sv
`timescale 1ns/1ps

// terminal output handshake checks, bound to the ring network top

module ring_net_sva (
  input logic                                           clk,
  input logic                                           rst_n,
  input logic [ring_pkg::NUM_PORTS-1:0]                 out_val,
  input logic [ring_pkg::NUM_PORTS-1:0]                 out_rdy,
  input logic [ring_pkg::NUM_PORTS*ring_pkg::MSG_W-1:0] out_msg
);

  // assertion failures so far
  int unsigned fail_count = 0;

  // nothing offered straight out of reset
  idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> out_val == '0)
    else
    begin
      $error("out_val high in the first cycle after reset");
      fail_count++;
    end

  // ------------------------------
  // per terminal hold rule
  // ------------------------------

  for (genvar k = 0; k < ring_pkg::NUM_PORTS; k++)
  begin : g_port
    // a stalled offer keeps val and message
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      out_val[k] && !out_rdy[k] |=>
        out_val[k] && $stable(out_msg[k*ring_pkg::MSG_W +: ring_pkg::MSG_W]))
      else
      begin
        $error("port %0d dropped or changed a stalled output", k);
        fail_count++;
      end
  end

endmodule

bind ring_net ring_net_sva hs_check (
  .clk     (clk),
  .rst_n   (rst_n),
  .out_val (out_val),
  .out_rdy (out_rdy),
  .out_msg (out_msg)
);

// File: bench/ring_net_tb.sv
`timescale 1ns/1ps

// ring network testbench
// directed and random traffic, per dest and src scoreboard, watchdog

module ring_net_tb;

  localparam int NUM_PORTS = ring_pkg::NUM_PORTS;
  localparam int MSG_W     = ring_pkg::MSG_W;

  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 3;
  localparam int SEED            = 4593;
  localparam int HOTSPOT_PER_SRC = 6;
  localparam int RANDOM_MSGS     = 200;

  // sweep, self plus tornado, hotspot, random
  localparam int TOTAL_MSGS = NUM_PORTS + 2 * NUM_PORTS + NUM_PORTS * HOTSPOT_PER_SRC
                              + RANDOM_MSGS;

  // 40 cycles per message, plus reset
  localparam longint TIMEOUT_NS = longint'(TOTAL_MSGS) * 40 * CLK_PERIOD
                                  + RST_CYCLES * CLK_PERIOD;

  localparam logic [NUM_PORTS-1:0] ALL_PORTS = '1;

  logic clk;
  logic rst_n;

  logic [NUM_PORTS-1:0]       in_val;
  wire  [NUM_PORTS-1:0]       in_rdy;
  logic [NUM_PORTS*MSG_W-1:0] in_msg;
  wire  [NUM_PORTS-1:0]       out_val;
  logic [NUM_PORTS-1:0]       out_rdy;
  wire  [NUM_PORTS*MSG_W-1:0] out_msg;

  // sinks with a coin-flip ready
  logic [NUM_PORTS-1:0] rdy_random;

  // messages still to send, per terminal
  logic [MSG_W-1:0] src_q [NUM_PORTS][$];
  // expected arrivals, by dest then src
  logic [MSG_W-1:0] exp_q [NUM_PORTS][NUM_PORTS][$];

  int delivered = 0;

  ring_clk_gen #(.CLK_PERIOD(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  ring_net uut (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_msg  (in_msg),
    .out_val (out_val),
    .out_rdy (out_rdy),
    .out_msg (out_msg)
  );

  // ------------------------------
  // helpers
  // ------------------------------

  // reference routing, a message leaves at its dest port
  function automatic int expected_port(input logic [MSG_W-1:0] msg);
    return msg[ring_pkg::DEST_LSB +: ring_pkg::PORT_W];
  endfunction

  // random opaque and payload
  function automatic logic [MSG_W-1:0] make_msg(input int dest, input int src);
    logic [MSG_W-1:0] msg;
    logic [31:0]      rnd;
    rnd = $urandom;
    msg = '0;
    msg[ring_pkg::DEST_LSB +: ring_pkg::PORT_W]      = dest[ring_pkg::PORT_W-1:0];
    msg[ring_pkg::SRC_LSB +: ring_pkg::PORT_W]       = src[ring_pkg::PORT_W-1:0];
    msg[ring_pkg::OPAQUE_LSB +: ring_pkg::OPAQUE_W]  = rnd[15:8];
    msg[ring_pkg::PAYLOAD_LSB +: ring_pkg::PAYLOAD_W] = rnd[7:0];
    return msg;
  endfunction

  task automatic queue_send(input int src, input int dest);
    src_q[src].push_back(make_msg(dest, src));
  endtask

  // all sources empty and every message delivered
  function automatic bit network_idle();
    for (int s = 0; s < NUM_PORTS; s++)
    begin
      if (src_q[s].size() != 0)
        return 1'b0;
      for (int d = 0; d < NUM_PORTS; d++)
        if (exp_q[d][s].size() != 0)
          return 1'b0;
    end
    return 1'b1;
  endfunction

  // ends on a rising edge, so the next phase loads clear of the drive
  task automatic wait_drained();
    do
      @(negedge clk);
    while (!network_idle());
    @(posedge clk);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
                             input string what);
    if (got !== want)
      abort_run($sformatf("Fail %0d ns: %s, got %0h, expected %0h", $time, what, got, want));
  endtask

  // sources hold the queue front until accepted
  task automatic drive_inputs();
    forever
    begin
      @(negedge clk);
      for (int k = 0; k < NUM_PORTS; k++)
      begin
        in_val[k] = (src_q[k].size() != 0);
        if (in_val[k])
          in_msg[k*MSG_W +: MSG_W] = src_q[k][0];
        out_rdy[k] = rdy_random[k] ? ($urandom_range(1) != 0) : 1'b1;
      end
    end
  endtask

  // ------------------------------
  // scoreboard and compare
  // ------------------------------

  always @(posedge clk)
  begin : record_sends
    logic [MSG_W-1:0] sent;
    if (rst_n)
      for (int k = 0; k < NUM_PORTS; k++)
        if (in_val[k] && in_rdy[k])
        begin
          sent = in_msg[k*MSG_W +: MSG_W];
          void'(src_q[k].pop_front());
          exp_q[expected_port(sent)][k].push_back(sent);
        end
  end

  always @(posedge clk)
  begin : compare_outputs
    logic [MSG_W-1:0] got;
    logic [MSG_W-1:0] want;
    int               src;
    if (rst_n)
      for (int k = 0; k < NUM_PORTS; k++)
        if (out_val[k] && out_rdy[k])
        begin
          got = out_msg[k*MSG_W +: MSG_W];
          src = got[ring_pkg::SRC_LSB +: ring_pkg::PORT_W];
          if (exp_q[k][src].size() == 0)
            abort_run($sformatf("port %0d got an unexpected message from source %0d",
                                k, src));
          want = exp_q[k][src].pop_front();
          check_equal(got, want, $sformatf("message at port %0d from source %0d", k, src));
          delivered++;
        end
  end

  // handshake assertion failures from the bound checker
  always @(posedge clk)
  begin : watch_assertions
    if (uut.hs_check.fail_count != 0)
      abort_run("a handshake assertion failed on a terminal output");
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    abort_run("timeout, the network failed to deliver all messages in time");
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial
  begin : main
    int src;
    int dest;
    void'($urandom(SEED));
    in_val     = '0;
    in_msg     = '0;
    out_rdy    = ALL_PORTS;
    rdy_random = '0;
    fork
      drive_inputs();
    join_none

    // quiet network out of reset
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_equal(out_val, '0, "out_val after reset");
    check_equal(in_rdy, ALL_PORTS, "in_rdy after reset");

    wait_drained();
    $display("phase: port 0 to every port");
    for (dest = 0; dest < NUM_PORTS; dest++)
      queue_send(0, dest);

    wait_drained();
    $display("phase: send to self, then tornado");
    for (src = 0; src < NUM_PORTS; src++)
    begin
      queue_send(src, src);
      queue_send(src, (src + 3) % NUM_PORTS);
    end

    // every source onto the last port, stalled at random
    wait_drained();
    $display("phase: hotspot on port %0d", NUM_PORTS - 1);
    rdy_random[NUM_PORTS-1] = 1'b1;
    for (int n = 0; n < HOTSPOT_PER_SRC; n++)
      for (src = 0; src < NUM_PORTS; src++)
        queue_send(src, NUM_PORTS - 1);

    wait_drained();
    $display("phase: random traffic");
    rdy_random = ALL_PORTS;
    repeat (RANDOM_MSGS)
    begin
      src  = $urandom_range(NUM_PORTS - 1);
      dest = $urandom_range(NUM_PORTS - 1);
      queue_send(src, dest);
    end

    wait_drained();
    check_equal(delivered, TOTAL_MSGS, "messages delivered");
    if (uut.hs_check.fail_count == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
      abort_run("a handshake assertion failed on a terminal output");
  end

endmodule

// File: project.f
rtl/ring_pkg.sv
rtl/ring_fifo.sv
rtl/ring_route_ctrl.sv
rtl/ring_router.sv
rtl/ring_net.sv
bench/ring_clk_gen.sv
bench/ring_net_sva.sv
bench/ring_net_tb.sv
